//--- filelist.f
hw/fp_format_pkg.sv
hw/fpu_regs_pkg.sv
hw/int_to_float.sv
hw/fp_add_sub.sv
hw/fpu_core.sv
hw/fpu_apb_regs.sv
hw/fpu_top.sv
verification/tb_clock.sv
verification/fpu_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the FPU testbench with Verilator; exit status reports the result
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module fpu_tb -f filelist.f

./obj_dir/Vfpu_tb

//--- verification/fpu_tb.sv
module fpu_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import fpu_regs_pkg::*;

  localparam int ADDR_WIDTH      = 5;
  localparam int CYCLES_PER_TEST = 100;
  localparam int N_DIRECTED      = 2;  // Bus error and busy refusal

  logic                  clk;
  logic                  rst;
  logic [ADDR_WIDTH-1:0] paddr = '0;
  logic                  psel = 1'b0;
  logic                  penable = 1'b0;
  logic                  pwrite = 1'b0;
  logic [31:0]           pwdata = '0;
  logic [31:0]           prdata;
  logic                  pready;
  logic                  pslverr;

  string       names[$];
  alu_op_t     ops[$];
  logic [31:0] a_vals[$];
  logic [31:0] b_vals[$];
  logic [31:0] expects[$];
  int          cycles = 0;
  int          cycle_limit = 0;

  tb_clock #(
    .PERIOD_NS    (40),
    .RESET_CYCLES (3)
  ) tb_clock_i (
    .clk (clk),
    .rst (rst)
  );

  fpu_top #(
    .ADDR_WIDTH (ADDR_WIDTH)
  ) fpu_top_i (
    .clk     (clk),
    .rst     (rst),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycle_limit != 0 && cycles >= cycle_limit) begin
      $display("*** FAILED ***");
      $fatal(1, "Timeout: no result after %0d cycles", cycles);
    end
  end

  function automatic void add_entry(string name, alu_op_t op, logic [31:0] a,
                                    logic [31:0] b, logic [31:0] expected);
    names.push_back(name);
    ops.push_back(op);
    a_vals.push_back(a);
    b_vals.push_back(b);
    expects.push_back(expected);
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
      $display("*** FAILED ***");
      $fatal(1, "Wrong value in %s", name);
    end
  endtask

  task automatic apb_transfer(input logic write, input logic [7:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
    @(posedge clk);
    #2;
    paddr   = ADDR_WIDTH'(addr);
    pwrite  = write;
    pwdata  = wdata;
    psel    = 1'b1;
    penable = 1'b0;
    @(posedge clk);
    #2;
    penable = 1'b1;
    #1;  // Mid access cycle
    rdata = prdata;
    err   = pslverr;
    check_value("pready in access cycle", 32'd1, 32'(pready));
    @(posedge clk);
    #2;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
    logic [31:0] ignored;
    apb_transfer(1'b1, addr, data, ignored, err);
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
    apb_transfer(1'b0, addr, 32'd0, data, err);
  endtask

  task automatic wait_idle(input string name);
    logic [31:0] status;
    logic        err;
    do begin
      apb_read(REG_STATUS, status, err);
      check_value({name, " status pslverr"}, 32'd0, 32'(err));
    end while (status[STATUS_BUSY_BIT]);
  endtask

  task automatic run_entry(input int idx);
    logic [31:0] rdata;
    logic        err;
    apb_write(REG_OP_A, a_vals[idx], err);
    check_value({names[idx], " op A pslverr"}, 32'd0, 32'(err));
    apb_write(REG_OP_B, b_vals[idx], err);
    check_value({names[idx], " op B pslverr"}, 32'd0, 32'(err));
    apb_write(REG_CTRL, 32'(ops[idx]), err);
    check_value({names[idx], " ctrl pslverr"}, 32'd0, 32'(err));
    wait_idle(names[idx]);
    apb_read(REG_RESULT, rdata, err);
    check_value({names[idx], " result pslverr"}, 32'd0, 32'(err));
    check_value(names[idx], expects[idx], rdata);
  endtask

  task automatic bus_error_test();
    logic [31:0] rdata;
    logic        err;
    apb_read(REG_STATUS, rdata, err);
    check_value("status after reset", 32'd0, rdata);
    check_value("status after reset pslverr", 32'd0, 32'(err));
    apb_read(8'h14, rdata, err);
    check_value("unmapped read pslverr", 32'd1, 32'(err));
  endtask

  task automatic busy_refusal_test();
    logic [31:0] rdata;
    logic        err;
    apb_write(REG_OP_A, 32'd1000, err);
    check_value("busy op A pslverr", 32'd0, 32'(err));
    apb_write(REG_CTRL, 32'(ALU_F_INT_FLOAT), err);
    check_value("busy start pslverr", 32'd0, 32'(err));
    apb_read(REG_STATUS, rdata, err);
    check_value("busy status", 32'd1, rdata);
    apb_write(REG_CTRL, 32'(ALU_F_ADD), err);  // Must be refused
    check_value("busy ctrl write pslverr", 32'd1, 32'(err));
    apb_read(REG_RESULT, rdata, err);
    // Still the last table result
    check_value("busy result untouched", expects[expects.size() - 1], rdata);
    wait_idle("busy");
    apb_read(REG_RESULT, rdata, err);
    check_value("busy pending result", 32'h447A0000, rdata);
  endtask

  initial begin
    add_entry("i2f 1",        ALU_F_INT_FLOAT, 32'd1,        32'd0,        32'h3F800000);
    add_entry("i2f -1",       ALU_F_INT_FLOAT, 32'hFFFFFFFF, 32'd0,        32'hBF800000);
    add_entry("i2f 6",        ALU_F_INT_FLOAT, 32'd6,        32'd0,        32'h40C00000);
    add_entry("i2f 1000",     ALU_F_INT_FLOAT, 32'd1000,     32'd0,        32'h447A0000);
    add_entry("i2f -32768",   ALU_F_INT_FLOAT, 32'hFFFF8000, 32'd0,        32'hC7000000);
    add_entry("i2f 0",        ALU_F_INT_FLOAT, 32'd0,        32'd0,        32'h00000000);
    add_entry("f2i 3.75",     ALU_F_FLOAT_INT, 32'h40700000, 32'd0,        32'd3);
    add_entry("f2i -2.5",     ALU_F_FLOAT_INT, 32'hC0200000, 32'd0,        32'hFFFFFFFE);
    add_entry("f2i 0.5",      ALU_F_FLOAT_INT, 32'h3F000000, 32'd0,        32'd0);
    add_entry("f2i 1000.0",   ALU_F_FLOAT_INT, 32'h447A0000, 32'd0,        32'd1000);
    add_entry("add 1.5+2.25", ALU_F_ADD,       32'h3FC00000, 32'h40100000, 32'h40700000);
    add_entry("add -1.5+4",   ALU_F_ADD,       32'hBFC00000, 32'h40800000, 32'h40200000);
    add_entry("add 1+1",      ALU_F_ADD,       32'h3F800000, 32'h3F800000, 32'h40000000);
    add_entry("add -2-0.5",   ALU_F_ADD,       32'hC0000000, 32'hBF000000, 32'hC0200000);
    add_entry("sub 4-1.5",    ALU_F_SUB,       32'h40800000, 32'h3FC00000, 32'h40200000);
    add_entry("sub 1.5-4",    ALU_F_SUB,       32'h3FC00000, 32'h40800000, 32'hC0200000);
    add_entry("sub 3-3",      ALU_F_SUB,       32'h40400000, 32'h40400000, 32'h00000000);
    add_entry("sub 1-0.75",   ALU_F_SUB,       32'h3F800000, 32'h3F400000, 32'h3E800000);
    cycle_limit = CYCLES_PER_TEST * (names.size() + N_DIRECTED);

    @(negedge rst);
    bus_error_test();
    for (int i = 0; i < names.size(); i++) begin
      run_entry(i);
    end
    busy_refusal_test();

    $display("*** PASSED ***");
    $finish;
  end

endmodule

//--- verification/tb_clock.sv
module tb_clock #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 3
) (
  output logic clk,
  output logic rst
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #2 rst = 1'b0;  // Released off the edge
  end

endmodule

//--- hw/fpu_top.sv
module fpu_top #(
  parameter int ADDR_WIDTH = 5
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [ADDR_WIDTH-1:0] paddr,
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  logic [31:0]           pwdata,
  output logic [31:0]           prdata,
  output logic                  pready,
  output logic                  pslverr
);

  import fpu_regs_pkg::*;

  logic [31:0] op_a;
  logic [31:0] op_b;
  alu_op_t     op;
  logic        start;
  logic [31:0] result;
  logic        busy;

  fpu_apb_regs #(
    .ADDR_WIDTH (ADDR_WIDTH)
  ) fpu_apb_regs_i (
    .clk     (clk),
    .rst     (rst),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .op_a    (op_a),
    .op_b    (op_b),
    .op      (op),
    .start   (start),
    .result  (result),
    .busy    (busy)
  );

  fpu_core fpu_core_i (
    .clk    (clk),
    .rst    (rst),
    .start  (start),
    .op     (op),
    .op_a   (op_a),
    .op_b   (op_b),
    .result (result),
    .busy   (busy)
  );

endmodule

//--- hw/fpu_apb_regs.sv
module fpu_apb_regs #(
  parameter int ADDR_WIDTH = 5
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [ADDR_WIDTH-1:0] paddr,
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  logic [31:0]           pwdata,
  output logic [31:0]           prdata,
  output logic                  pready,
  output logic                  pslverr,
  output logic [31:0]           op_a,
  output logic [31:0]           op_b,
  output fpu_regs_pkg::alu_op_t op,
  output logic                  start,
  input  logic [31:0]           result,
  input  logic                  busy
);

  import fpu_regs_pkg::*;

  logic    access;
  logic    wr_en;
  logic    sel_a;
  logic    sel_b;
  logic    sel_ctrl;
  logic    sel_status;
  logic    sel_result;
  logic    mapped;
  logic    ctrl_wr;
  alu_op_t wr_op;
  alu_op_t op_q;

  assign access = psel & penable;  // APB access phase
  assign wr_en  = access & pwrite;

  assign sel_a      = (paddr == ADDR_WIDTH'(REG_OP_A));
  assign sel_b      = (paddr == ADDR_WIDTH'(REG_OP_B));
  assign sel_ctrl   = (paddr == ADDR_WIDTH'(REG_CTRL));
  assign sel_status = (paddr == ADDR_WIDTH'(REG_STATUS));
  assign sel_result = (paddr == ADDR_WIDTH'(REG_RESULT));
  assign mapped     = sel_a | sel_b | sel_ctrl | sel_status | sel_result;

  assign ctrl_wr = wr_en & sel_ctrl & ~busy;  // Refused while busy
  assign wr_op   = alu_op_t'(pwdata[CTRL_OP_W-1:0]);
  assign start   = ctrl_wr & (wr_op != ALU_NOP);

  // Core samples the opcode on the same edge as start
  assign op = ctrl_wr ? wr_op : op_q;

  assign pready  = 1'b1;
  assign pslverr = access & (~mapped | (pwrite & sel_ctrl & busy));

  always_ff @(posedge clk) begin
    if (rst) begin
      op_q <= ALU_NOP;
    end else if (ctrl_wr) begin
      op_q <= wr_op;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en && sel_a) begin
      op_a <= pwdata;
    end
    if (wr_en && sel_b) begin
      op_b <= pwdata;
    end
  end

  always_comb begin
    prdata = '0;
    if (access && !pwrite) begin
      if (sel_a) begin
        prdata = op_a;
      end else if (sel_b) begin
        prdata = op_b;
      end else if (sel_ctrl) begin
        prdata = 32'(op_q);
      end else if (sel_status) begin
        prdata[STATUS_BUSY_BIT] = busy;
      end else if (sel_result) begin
        prdata = result;
      end
    end
  end

  a_penable_psel : assert property (@(posedge clk) disable iff (rst)
    penable |-> psel)
    else $error("APB penable without psel");

endmodule

//--- hw/fpu_core.sv
module fpu_core (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  start,
  input  fpu_regs_pkg::alu_op_t op,
  input  logic [31:0]           op_a,
  input  logic [31:0]           op_b,
  output logic [31:0]           result,
  output logic                  busy
);

  import fp_format_pkg::*;
  import fpu_regs_pkg::*;

  logic                start_conv;
  logic                conv_done;
  logic [31:0]         conv_result;
  logic                sub_sel;
  logic [31:0]         add_sub_sum;
  logic [FP_EXP_W-1:0] f2i_exp;
  logic [FP_EXP_W-1:0] f2i_shift;
  logic [31:0]         f2i_mag;
  logic [31:0]         f2i_result;

  assign start_conv = start && (op == ALU_F_INT_FLOAT);
  assign sub_sel    = (op == ALU_F_SUB);

  int_to_float int_to_float_i (
    .clk         (clk),
    .rst         (rst),
    .start_conv  (start_conv),
    .operand     (op_a),
    .conv_result (conv_result),
    .conv_done   (conv_done)
  );

  fp_add_sub fp_add_sub_i (
    .a   (op_a),
    .b   (op_b),
    .sub (sub_sel),
    .sum (add_sub_sum)
  );

  // Float to integer, fraction bits shifted out
  assign f2i_exp   = op_a[FP_SIGN_BIT-1 -: FP_EXP_W];
  assign f2i_shift = FP_INT_MAX_EXP - f2i_exp;
  assign f2i_mag   = {8'b0, 1'b1, op_a[FP_MAN_W-1:0]} >> f2i_shift;

  always_comb begin
    if (f2i_exp < FP_BIAS) begin
      f2i_result = '0;  // Magnitude below one
    end else if (op_a[FP_SIGN_BIT]) begin
      f2i_result = ~f2i_mag + 32'd1;
    end else begin
      f2i_result = f2i_mag;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      result <= '0;
      busy   <= 1'b0;
    end else if (start_conv) begin
      busy <= 1'b1;  // Result waits for the scan
    end else if (conv_done) begin
      busy   <= 1'b0;
      result <= conv_result;
    end else if (start) begin
      case (op)
        ALU_F_FLOAT_INT:      result <= f2i_result;
        ALU_F_ADD, ALU_F_SUB: result <= add_sub_sum;
        default:              result <= result;
      endcase
    end
  end

  a_done_in_busy : assert property (@(posedge clk) disable iff (rst)
    conv_done |-> busy)
    else $error("conv_done outside a conversion");

endmodule

//--- hw/fp_add_sub.sv
module fp_add_sub (
  input  logic [31:0] a,
  input  logic [31:0] b,
  input  logic        sub,
  output logic [31:0] sum
);

  import fp_format_pkg::*;

  localparam int MW = FP_MAN_W + 1;  // Mantissa with hidden one

  logic                sign_a;
  logic                sign_b;
  logic [FP_EXP_W-1:0] exp_a;
  logic [FP_EXP_W-1:0] exp_b;
  logic [MW-1:0]       man_a;
  logic [MW-1:0]       man_b;
  logic                a_big;
  logic                sign_big;
  logic                sign_small;
  logic [FP_EXP_W-1:0] exp_big;
  logic [FP_EXP_W-1:0] exp_small;
  logic [FP_EXP_W-1:0] exp_diff;
  logic [MW-1:0]       man_big;
  logic [MW-1:0]       man_small;
  logic [MW-1:0]       man_aligned;
  logic [MW:0]         mag;
  logic [4:0]          lead_zeros;
  logic [MW-1:0]       man_norm;
  logic [FP_EXP_W-1:0] exp_norm;

  assign sign_a = a[FP_SIGN_BIT];
  assign sign_b = b[FP_SIGN_BIT] ^ sub;  // a - b == a + (-b)
  assign exp_a  = a[FP_SIGN_BIT-1 -: FP_EXP_W];
  assign exp_b  = b[FP_SIGN_BIT-1 -: FP_EXP_W];
  assign man_a  = {|exp_a, a[FP_MAN_W-1:0]};  // Zero exponent means zero
  assign man_b  = {|exp_b, b[FP_MAN_W-1:0]};

  // Exponent and mantissa compare as one unsigned field
  assign a_big = a[FP_SIGN_BIT-1:0] >= b[FP_SIGN_BIT-1:0];

  assign sign_big   = a_big ? sign_a : sign_b;
  assign sign_small = a_big ? sign_b : sign_a;
  assign exp_big    = a_big ? exp_a : exp_b;
  assign exp_small  = a_big ? exp_b : exp_a;
  assign man_big    = a_big ? man_a : man_b;
  assign man_small  = a_big ? man_b : man_a;

  assign exp_diff    = exp_big - exp_small;
  assign man_aligned = man_small >> exp_diff;

  assign mag = (sign_big == sign_small) ? {1'b0, man_big} + {1'b0, man_aligned}
                                        : {1'b0, man_big} - {1'b0, man_aligned};

  always_comb begin
    lead_zeros = '0;
    for (int i = 0; i < MW; i++) begin
      if (mag[i]) begin
        lead_zeros = 5'(MW - 1 - i);
      end
    end
    man_norm = mag[MW-1:0] << lead_zeros;
    exp_norm = exp_big - FP_EXP_W'(lead_zeros);
    if (mag[MW]) begin
      sum = {sign_big, exp_big + FP_EXP_W'(1), mag[MW-1:1]};  // Carry out
    end else if (mag == '0) begin
      sum = '0;  // Exact cancel gives +0.0
    end else begin
      sum = {sign_big, exp_norm, man_norm[FP_MAN_W-1:0]};
    end
  end

endmodule

//--- hw/int_to_float.sv
module int_to_float (
  input  logic        clk,
  input  logic        rst,
  input  logic        start_conv,
  input  logic [31:0] operand,
  output logic [31:0] conv_result,
  output logic        conv_done
);

  import fp_format_pkg::*;

  logic                 running;
  logic [4:0]           cnt;  // Bit under scan
  logic                 found;  // Nonzero input seen
  logic                 sign;
  logic [31:0]          operand_abs;
  logic [31:0]          mag;
  logic [31:0]          scan;
  logic [4:0]           shift_point;
  logic [31+FP_MAN_W:0] man_wide;
  logic [FP_EXP_W-1:0]  exponent;

  assign operand_abs = operand[31] ? (~operand + 32'd1) : operand;

  always_ff @(posedge clk) begin
    if (rst) begin
      running   <= 1'b0;
      cnt       <= '0;
      found     <= 1'b0;
      conv_done <= 1'b0;
    end else if (start_conv) begin
      running   <= 1'b1;
      cnt       <= '0;
      found     <= 1'b0;
      conv_done <= 1'b0;
    end else if (running) begin
      if (conv_done) begin
        running   <= 1'b0;
        conv_done <= 1'b0;
      end else begin
        cnt       <= cnt + 5'd1;
        conv_done <= (cnt == 5'd31);  // Last bit this cycle
        if (scan[0]) begin
          found <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start_conv) begin
      sign <= operand[31];
      mag  <= operand_abs;
      scan <= operand_abs;
    end else if (running && !conv_done) begin
      scan <= scan >> 1;
      if (scan[0]) begin
        shift_point <= cnt;  // Highest set bit wins
      end
    end
  end

  // Leading one lands on bit FP_MAN_W, lower bits truncated
  assign man_wide = {mag, {FP_MAN_W{1'b0}}} >> shift_point;
  assign exponent = FP_EXP_W'(shift_point) + FP_BIAS;

  assign conv_result = found ? {sign, exponent, man_wide[FP_MAN_W-1:0]} : '0;

  a_no_restart : assert property (@(posedge clk) disable iff (rst)
    start_conv |-> !running)
    else $error("int_to_float restarted during a scan");

endmodule

//--- hw/fpu_regs_pkg.sv
package fpu_regs_pkg;

  localparam int CTRL_OP_W = 3;  // Opcode bits in CTRL
  localparam int STATUS_BUSY_BIT = 0;

  typedef enum logic [CTRL_OP_W-1:0] {
    ALU_NOP         = 3'd0,
    ALU_F_INT_FLOAT = 3'd1,
    ALU_F_FLOAT_INT = 3'd2,
    ALU_F_ADD       = 3'd3,
    ALU_F_SUB       = 3'd4
  } alu_op_t;

  // Byte offsets on the APB side
  localparam logic [7:0] REG_OP_A = 8'h00;
  localparam logic [7:0] REG_OP_B = 8'h04;
  localparam logic [7:0] REG_CTRL = 8'h08;
  localparam logic [7:0] REG_STATUS = 8'h0C;
  localparam logic [7:0] REG_RESULT = 8'h10;

endpackage

//--- hw/fp_format_pkg.sv
package fp_format_pkg;

  // Single-precision layout, sign | exponent | mantissa
  localparam int FP_EXP_W = 8;
  localparam int FP_MAN_W = 23;
  localparam int FP_SIGN_BIT = 31;  // Exponent sits just below

  localparam logic [FP_EXP_W-1:0] FP_BIAS = 8'd127;

  // Beyond this exponent the integer part needs more than 24 bits
  localparam logic [FP_EXP_W-1:0] FP_INT_MAX_EXP = 8'd150;

endpackage
